//--- hw/isa_pkg.sv
/*
  RV32IM instruction field types and encodings used at the issue stage.
  Only the fields the hazard logic looks at are covered. No compressed
  or floating point encodings.
*/
package isa_pkg;

  // Raw instruction word and register address
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_addr_t;

  // Instruction fields
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // Architectural integer registers, x0 included
  localparam int unsigned num_regs_lp = 32;

  // Major opcodes
  localparam opcode_t OPC_OP       = 7'b0110011;
  localparam opcode_t OPC_OP_IMM   = 7'b0010011;
  localparam opcode_t OPC_LUI      = 7'b0110111;
  localparam opcode_t OPC_AUIPC    = 7'b0010111;
  localparam opcode_t OPC_JAL      = 7'b1101111;
  localparam opcode_t OPC_JALR     = 7'b1100111;
  localparam opcode_t OPC_BRANCH   = 7'b1100011;
  localparam opcode_t OPC_LOAD     = 7'b0000011;
  localparam opcode_t OPC_STORE    = 7'b0100011;
  localparam opcode_t OPC_MISC_MEM = 7'b0001111;
  localparam opcode_t OPC_SYSTEM   = 7'b1110011;

  // M extension lives under OP with this funct7
  localparam funct7_t MULDIV_F7 = 7'b0000001;

  // Under MULDIV_F7, funct3 0..3 are MUL variants and 4..7 are DIV/REM
  localparam funct3_t F3_DIV_FIRST = 3'd4;

  // SYSTEM with funct3 zero is ECALL/EBREAK/xRET/WFI, anything else a CSR op
  localparam funct3_t F3_PRIV = 3'd0;

endpackage

//--- hw/issue_pkg.sv
/*
  Issue-stage definitions: execute pipe depth, producer classes and the
  flag layout of one dependency entry. Latencies are fixed by the core.
*/
package issue_pkg;

  // Execute stages tracked by the dependency pipe (EX1..EX3)
  localparam int unsigned exe_depth_lp = 3;

  // Producer class of a decoded instruction
  typedef logic [1:0] pclass_t;

  // Result forwarded, never stalls a consumer
  localparam pclass_t PCLASS_ALU  = 2'd0;
  // Result ready after EX2
  localparam pclass_t PCLASS_LOAD = 2'd1;
  // Result ready after EX3
  localparam pclass_t PCLASS_MUL  = 2'd2;
  // Divide/remainder, late writeback tracked by the scoreboard
  localparam pclass_t PCLASS_LONG = 2'd3;

  // Per-stage flags of a dependency entry
  typedef logic [3:0] dep_flags_t;

  // Entry holds a dispatched instruction
  localparam int unsigned DEP_VALID = 0;
  // Load or store
  localparam int unsigned DEP_MEM   = 1;
  // CSR or other SYSTEM instruction
  localparam int unsigned DEP_CSR   = 2;
  // Writes a nonzero rd
  localparam int unsigned DEP_WB    = 3;

endpackage

//--- hw/instr_decoder.sv
/*
  Issue-stage decode of one RV32IM instruction. Only register usage and
  hazard-relevant class bits are produced. Unknown opcodes decode as a
  no-op. Fields naming x0 never report as read or written.
*/
`timescale 1ns/1ps

module instr_decoder
(
  input  isa_pkg::instr_t    instr_i,
  output isa_pkg::reg_addr_t rs1_o,
  output isa_pkg::reg_addr_t rs2_o,
  output isa_pkg::reg_addr_t rd_o,
  output logic               rs1_used_o,
  output logic               rs2_used_o,
  output logic               rd_wr_o,
  output logic               is_mem_o,
  output logic               is_csr_o,
  output logic               is_fence_o,
  output issue_pkg::pclass_t pclass_o
);

  import isa_pkg::*;
  import issue_pkg::*;

  opcode_t opcode;
  funct3_t funct3;
  funct7_t funct7;

  // Raw usage before the x0 filter
  logic rs1_use;
  logic rs2_use;
  logic rd_use;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  assign rd_o  = instr_i[11:7];
  assign rs1_o = instr_i[19:15];
  assign rs2_o = instr_i[24:20];

  always_comb
  begin
    rs1_use    = 1'b0;
    rs2_use    = 1'b0;
    rd_use     = 1'b0;
    is_mem_o   = 1'b0;
    is_csr_o   = 1'b0;
    is_fence_o = 1'b0;
    pclass_o   = PCLASS_ALU;

    unique case (opcode)
      OPC_OP:
      begin
        rs1_use = 1'b1;
        rs2_use = 1'b1;
        rd_use  = 1'b1;
        if (funct7 == MULDIV_F7)
        begin
          pclass_o = (funct3 >= F3_DIV_FIRST) ? PCLASS_LONG : PCLASS_MUL;
        end
      end
      OPC_OP_IMM, OPC_JALR:
      begin
        rs1_use = 1'b1;
        rd_use  = 1'b1;
      end
      OPC_LUI, OPC_AUIPC, OPC_JAL:
      begin
        rd_use = 1'b1;
      end
      OPC_BRANCH:
      begin
        rs1_use = 1'b1;
        rs2_use = 1'b1;
      end
      OPC_LOAD:
      begin
        rs1_use  = 1'b1;
        rd_use   = 1'b1;
        is_mem_o = 1'b1;
        pclass_o = PCLASS_LOAD;
      end
      OPC_STORE:
      begin
        rs1_use  = 1'b1;
        rs2_use  = 1'b1;
        is_mem_o = 1'b1;
      end
      // FENCE and FENCE.I, no register traffic
      OPC_MISC_MEM:
      begin
        is_fence_o = 1'b1;
      end
      OPC_SYSTEM:
      begin
        // Every SYSTEM op serializes, CSR ops also move data
        is_csr_o = 1'b1;
        if (funct3 != F3_PRIV)
        begin
          // Immediate forms (funct3[2] set) take no rs1
          rs1_use = ~funct3[2];
          rd_use  = 1'b1;
        end
      end
      default:
      begin
        // Unknown opcode, treated as a no-op
      end
    endcase
  end

  // x0 is hardwired, so it never creates a dependency
  assign rs1_used_o = rs1_use & (rs1_o != '0);
  assign rs2_used_o = rs2_use & (rs2_o != '0);
  assign rd_wr_o    = rd_use  & (rd_o  != '0);

  // Memory and CSR paths are exclusive in the execute stages
  always_comb
  begin
    assert (!(is_mem_o && is_csr_o))
      else $error("decoder flagged an instruction as both memory and CSR");
  end

endmodule

//--- hw/reg_scoreboard.sv
/*
  Pending-result scoreboard for late divide writebacks. One bit per
  register, x0 is never scored. Set and clear take effect at the clock
  edge, so busy outputs reflect them the following cycle.
*/
`timescale 1ns/1ps

module reg_scoreboard
(
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               score_v_i,
  input  isa_pkg::reg_addr_t score_rd_i,
  input  logic               clear_v_i,
  input  isa_pkg::reg_addr_t clear_rd_i,
  input  isa_pkg::reg_addr_t rs1_i,
  input  isa_pkg::reg_addr_t rs2_i,
  input  isa_pkg::reg_addr_t rd_i,
  output logic               rs1_busy_o,
  output logic               rs2_busy_o,
  output logic               rd_busy_o
);

  import isa_pkg::*;

  logic [num_regs_lp-1:0] pending_r;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      pending_r <= '0;
    end
    else
    begin
      if (clear_v_i)
      begin
        pending_r[clear_rd_i] <= 1'b0;
      end
      if (score_v_i && (score_rd_i != '0))
      begin
        pending_r[score_rd_i] <= 1'b1;
      end
    end
  end

  assign rs1_busy_o = pending_r[rs1_i];
  assign rs2_busy_o = pending_r[rs2_i];
  assign rd_busy_o  = pending_r[rd_i];

  // Every late writeback must belong to an outstanding divide
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    clear_v_i |-> pending_r[clear_rd_i])
    else $error("late writeback to x%0d with no pending result", clear_rd_i);

  // The issue logic must stall a divide whose rd is still outstanding
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (score_v_i && (score_rd_i != '0)) |-> !pending_r[score_rd_i])
    else $error("divide scored onto already pending x%0d", score_rd_i);

endmodule

//--- hw/hazard_detector.sv
/*
  Issue hazard checks against a three-entry execute dependency pipe.
  The pipe shifts every cycle and takes a bubble when nothing dispatches.
  dispatch_v_o is combinational. The driver must hold the instruction
  until it sees dispatch_v_o high.
*/
`timescale 1ns/1ps

module hazard_detector
(
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               instr_v_i,
  input  isa_pkg::reg_addr_t rs1_i,
  input  isa_pkg::reg_addr_t rs2_i,
  input  isa_pkg::reg_addr_t rd_i,
  input  logic               rs1_used_i,
  input  logic               rs2_used_i,
  input  logic               rd_wr_i,
  input  logic               is_mem_i,
  input  logic               is_csr_i,
  input  logic               is_fence_i,
  input  issue_pkg::pclass_t pclass_i,
  input  logic               rs1_busy_i,
  input  logic               rs2_busy_i,
  input  logic               rd_busy_i,
  input  logic               freeze_i,
  input  logic               mem_ready_i,
  input  logic               long_ready_i,
  input  logic               mem_idle_i,
  output logic               dispatch_v_o
);

  import isa_pkg::*;
  import issue_pkg::*;

  // Stage index 0 is EX1
  dep_flags_t flags_r  [exe_depth_lp];
  reg_addr_t  rd_r     [exe_depth_lp];
  pclass_t    pclass_r [exe_depth_lp];

  dep_flags_t             entry_flags;
  logic [exe_depth_lp-1:0] src_hit;
  logic                   is_long;
  logic                   fwd_haz;
  logic                   sb_haz;
  logic                   serial_haz;
  logic                   fence_haz;
  logic                   long_haz;
  logic                   struct_haz;
  logic                   any_valid;
  logic                   mem_in_pipe;

  // Last stage whose end a producer class needs before its result forwards
  function automatic int unsigned ready_stage(input pclass_t pc);
    int unsigned stage;
    case (pc)
      PCLASS_LOAD: stage = 2;
      PCLASS_MUL:  stage = 3;
      // ALU forwards from EX1, divides are covered by the scoreboard
      default:     stage = 0;
    endcase
    return stage;
  endfunction

  assign is_long = (pclass_i == PCLASS_LONG);

  always_comb
  begin
    fwd_haz    = 1'b0;
    serial_haz = 1'b0;
    any_valid  = 1'b0;
    for (int i = 0; i < exe_depth_lp; i++)
    begin
      src_hit[i] = flags_r[i][DEP_WB]
                   & ((rs1_used_i & (rs1_i == rd_r[i]))
                      | (rs2_used_i & (rs2_i == rd_r[i])));
      // Stage i+1 result not yet available to a consumer entering EX1
      if (src_hit[i] && (ready_stage(pclass_r[i]) > i + 1))
      begin
        fwd_haz = 1'b1;
      end
      serial_haz = serial_haz | flags_r[i][DEP_CSR];
      any_valid  = any_valid  | flags_r[i][DEP_VALID];
    end
  end

  assign mem_in_pipe = flags_r[0][DEP_MEM] | flags_r[1][DEP_MEM];

  assign sb_haz = (rs1_used_i & rs1_busy_i)
                  | (rs2_used_i & rs2_busy_i)
                  | (rd_wr_i & rd_busy_i);

  assign fence_haz  = is_fence_i & (~mem_idle_i | mem_in_pipe);
  assign long_haz   = is_long & (~long_ready_i | any_valid);
  assign struct_haz = freeze_i | (is_mem_i & ~mem_ready_i);

  assign dispatch_v_o = instr_v_i
                        & ~(fwd_haz | sb_haz | serial_haz | fence_haz | long_haz | struct_haz);

  always_comb
  begin
    entry_flags            = '0;
    entry_flags[DEP_VALID] = 1'b1;
    entry_flags[DEP_MEM]   = is_mem_i;
    entry_flags[DEP_CSR]   = is_csr_i;
    entry_flags[DEP_WB]    = rd_wr_i;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 0; i < exe_depth_lp; i++)
      begin
        flags_r[i] <= '0;
      end
    end
    else
    begin
      flags_r[0] <= dispatch_v_o ? entry_flags : '0;
      for (int i = 1; i < exe_depth_lp; i++)
      begin
        flags_r[i] <= flags_r[i-1];
      end
    end
  end

  // Payload follows the flags, qualified by them when read
  always_ff @(posedge clk_i)
  begin
    rd_r[0]     <= dispatch_v_o ? rd_i : '0;
    pclass_r[0] <= dispatch_v_o ? pclass_i : PCLASS_ALU;
    for (int i = 1; i < exe_depth_lp; i++)
    begin
      rd_r[i]     <= rd_r[i-1];
      pclass_r[i] <= pclass_r[i-1];
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dispatch_v_o |-> instr_v_i)
    else $error("dispatch without a valid instruction");

endmodule

//--- hw/issue_ctrl.sv
/*
  Issue-stage hazard checker top level. Divides are scored on dispatch
  and cleared by the external late writeback strobe, one per divide.
  No flush support. Instructions must be held until dispatched.
*/
`timescale 1ns/1ps

module issue_ctrl
(
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               instr_v_i,
  input  isa_pkg::instr_t    instr_i,
  input  logic               freeze_i,
  input  logic               mem_ready_i,
  input  logic               long_ready_i,
  input  logic               mem_idle_i,
  input  logic               late_wb_v_i,
  input  isa_pkg::reg_addr_t late_wb_rd_i,
  output logic               dispatch_v_o
);

  import isa_pkg::*;
  import issue_pkg::*;

  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  logic      rs1_used;
  logic      rs2_used;
  logic      rd_wr;
  logic      is_mem;
  logic      is_csr;
  logic      is_fence;
  pclass_t   pclass;
  logic      rs1_busy;
  logic      rs2_busy;
  logic      rd_busy;
  logic      score_v;

  instr_decoder u_decoder
  (
    .instr_i    (instr_i),
    .rs1_o      (rs1),
    .rs2_o      (rs2),
    .rd_o       (rd),
    .rs1_used_o (rs1_used),
    .rs2_used_o (rs2_used),
    .rd_wr_o    (rd_wr),
    .is_mem_o   (is_mem),
    .is_csr_o   (is_csr),
    .is_fence_o (is_fence),
    .pclass_o   (pclass)
  );

  // Only divides writing a real register leave a pending result
  assign score_v = dispatch_v_o & (pclass == PCLASS_LONG) & rd_wr;

  reg_scoreboard u_scoreboard
  (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .score_v_i  (score_v),
    .score_rd_i (rd),
    .clear_v_i  (late_wb_v_i),
    .clear_rd_i (late_wb_rd_i),
    .rs1_i      (rs1),
    .rs2_i      (rs2),
    .rd_i       (rd),
    .rs1_busy_o (rs1_busy),
    .rs2_busy_o (rs2_busy),
    .rd_busy_o  (rd_busy)
  );

  hazard_detector u_detector
  (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .instr_v_i    (instr_v_i),
    .rs1_i        (rs1),
    .rs2_i        (rs2),
    .rd_i         (rd),
    .rs1_used_i   (rs1_used),
    .rs2_used_i   (rs2_used),
    .rd_wr_i      (rd_wr),
    .is_mem_i     (is_mem),
    .is_csr_i     (is_csr),
    .is_fence_i   (is_fence),
    .pclass_i     (pclass),
    .rs1_busy_i   (rs1_busy),
    .rs2_busy_i   (rs2_busy),
    .rd_busy_i    (rd_busy),
    .freeze_i     (freeze_i),
    .mem_ready_i  (mem_ready_i),
    .long_ready_i (long_ready_i),
    .mem_idle_i   (mem_idle_i),
    .dispatch_v_o (dispatch_v_o)
  );

endmodule

//--- tb/issue_model.svh
/*
  Reference model of the issue rules, included inside the testbench module.
  Decodes straight from the RV32IM encoding. Keeps a shadow EX1..EX3 pipe
  and shadow divide pending bits. Needs isa_pkg and issue_pkg imported.
*/
`ifndef ISSUE_MODEL_SVH
`define ISSUE_MODEL_SVH

// Shadow execute pipe, index 0 is EX1
bit        sh_v    [exe_depth_lp];
bit        sh_mem  [exe_depth_lp];
bit        sh_csr  [exe_depth_lp];
bit        sh_wb   [exe_depth_lp];
reg_addr_t sh_rd   [exe_depth_lp];
pclass_t   sh_cls  [exe_depth_lp];
bit        sh_pend [num_regs_lp];

// Decoded view of the instruction at issue
reg_addr_t m_rs1;
reg_addr_t m_rs2;
reg_addr_t m_rd;
bit        m_r1;
bit        m_r2;
bit        m_w;
bit        m_mem;
bit        m_csr;
bit        m_fence;
pclass_t   m_cls;

function automatic void decode_model(input instr_t ins);
  opcode_t op;
  funct3_t f3;
  op    = ins[6:0];
  f3    = ins[14:12];
  m_rs1 = ins[19:15];
  m_rs2 = ins[24:20];
  m_rd  = ins[11:7];
  {m_r1, m_r2, m_w, m_mem, m_csr, m_fence} = '0;
  case (op)
    OPC_OP:                      {m_r1, m_r2, m_w} = 3'b111;
    OPC_OP_IMM, OPC_JALR:        {m_r1, m_w} = 2'b11;
    OPC_LUI, OPC_AUIPC, OPC_JAL: m_w = 1'b1;
    OPC_BRANCH:                  {m_r1, m_r2} = 2'b11;
    OPC_LOAD:                    {m_r1, m_w, m_mem} = 3'b111;
    OPC_STORE:                   {m_r1, m_r2, m_mem} = 3'b111;
    OPC_MISC_MEM:                m_fence = 1'b1;
    OPC_SYSTEM:
    begin
      // funct3 zero is a privileged op, upper half uses an immediate
      m_csr = 1'b1;
      m_w   = (f3 != 3'd0);
      m_r1  = (f3 != 3'd0) && !f3[2];
    end
    default:
    begin
    end
  endcase
  if (op == OPC_LOAD)
    m_cls = PCLASS_LOAD;
  else if (op == OPC_OP && ins[31:25] == MULDIV_F7)
    m_cls = f3[2] ? PCLASS_LONG : PCLASS_MUL;
  else
    m_cls = PCLASS_ALU;
  // x0 carries no dependency
  m_r1 = m_r1 && (m_rs1 != 5'd0);
  m_r2 = m_r2 && (m_rs2 != 5'd0);
  m_w  = m_w && (m_rd != 5'd0);
endfunction

function automatic bit expect_dispatch(input bit v, input bit frz, input bit mrdy,
                                       input bit lrdy, input bit midle);
  bit haz;
  bit pipe_busy;
  bit src_hit;
  haz       = frz || (m_mem && !mrdy);
  pipe_busy = 1'b0;
  for (int i = 0; i < exe_depth_lp; i++)
  begin
    src_hit = sh_wb[i] && ((m_r1 && m_rs1 == sh_rd[i]) || (m_r2 && m_rs2 == sh_rd[i]));
    // Loads forward from EX2 on, multiplies from EX3 on
    if (src_hit && ((sh_cls[i] == PCLASS_LOAD && i == 0) || (sh_cls[i] == PCLASS_MUL && i < 2)))
      haz = 1'b1;
    if (sh_csr[i])
      haz = 1'b1;
    pipe_busy = pipe_busy || sh_v[i];
  end
  if ((m_r1 && sh_pend[m_rs1]) || (m_r2 && sh_pend[m_rs2]) || (m_w && sh_pend[m_rd]))
    haz = 1'b1;
  if (m_fence && (!midle || sh_mem[0] || sh_mem[1]))
    haz = 1'b1;
  if (m_cls == PCLASS_LONG && (!lrdy || pipe_busy))
    haz = 1'b1;
  return v && !haz;
endfunction

// Commit one clock edge to the shadow pipe and pending bits
function automatic void advance_model(input bit disp, input bit wb_v, input reg_addr_t wb_rd);
  for (int i = exe_depth_lp - 1; i > 0; i--)
  begin
    sh_v[i]   = sh_v[i-1];
    sh_mem[i] = sh_mem[i-1];
    sh_csr[i] = sh_csr[i-1];
    sh_wb[i]  = sh_wb[i-1];
    sh_rd[i]  = sh_rd[i-1];
    sh_cls[i] = sh_cls[i-1];
  end
  sh_v[0]   = disp;
  sh_mem[0] = disp && m_mem;
  sh_csr[0] = disp && m_csr;
  sh_wb[0]  = disp && m_w;
  sh_rd[0]  = m_rd;
  sh_cls[0] = m_cls;
  if (wb_v)
    sh_pend[wb_rd] = 1'b0;
  if (disp && m_cls == PCLASS_LONG && m_w)
    sh_pend[m_rd] = 1'b1;
endfunction

`endif

//--- tb/issue_ctrl_tb.sv
/*
  Random-stimulus testbench for the issue hazard checker. Register fields
  come from x0..x3 so dependencies are frequent. Expected dispatch comes
  from the model in issue_model.svh, checked by concurrent assertions.
*/
`timescale 1ns/1ps

module issue_ctrl_tb;

  import isa_pkg::*;
  import issue_pkg::*;

  localparam int unsigned num_instr_lp  = 2000;
  localparam int unsigned max_cycles_lp = 40 * num_instr_lp;
  localparam int unsigned seed_lp       = 32'ha1d87399;

  logic      clk;
  logic      rst_n;
  logic      instr_v;
  instr_t    instr;
  logic      freeze;
  logic      mem_ready;
  logic      long_ready;
  logic      mem_idle;
  logic      late_wb_v;
  reg_addr_t late_wb_rd;
  logic      dispatch_v;

  bit          exp_disp;
  bit          holding;
  int unsigned issued;
  int unsigned cycles;
  int unsigned mismatch_cnt;
  int unsigned rule_cnt;
  // Cycles left before a scored divide may write back
  int unsigned wb_wait [num_regs_lp];

  `include "issue_model.svh"

  issue_ctrl dut
  (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .instr_v_i    (instr_v),
    .instr_i      (instr),
    .freeze_i     (freeze),
    .mem_ready_i  (mem_ready),
    .long_ready_i (long_ready),
    .mem_idle_i   (mem_idle),
    .late_wb_v_i  (late_wb_v),
    .late_wb_rd_i (late_wb_rd),
    .dispatch_v_o (dispatch_v)
  );

  always
  begin
    #4 clk = ~clk;
  end

  assert property (@(posedge clk) disable iff (!rst_n) dispatch_v == exp_disp)
    else
    begin
      mismatch_cnt++;
      $display("mismatch at %0t: dispatch_v_o=%0b, expected %0b for instr %h",
               $time, $sampled(dispatch_v), $sampled(exp_disp), $sampled(instr));
    end

  // Frozen issue or an empty slot never dispatches
  assert property (@(posedge clk) disable iff (!rst_n) (freeze || !instr_v) |-> !dispatch_v)
    else
    begin
      rule_cnt++;
      $display("mismatch at %0t: dispatch while frozen or without a valid instruction", $time);
    end

  // A CSR instruction anywhere in EX1..EX3 blocks everything
  assert property (@(posedge clk) disable iff (!rst_n)
    (sh_csr[0] || sh_csr[1] || sh_csr[2]) |-> !dispatch_v)
    else
    begin
      rule_cnt++;
      $display("mismatch at %0t: dispatch behind a CSR instruction", $time);
    end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= max_cycles_lp)
    begin
      $display("timeout after %0d cycles, %0d of %0d instructions dispatched",
               cycles, issued, num_instr_lp);
      $display("Simulation failed");
      $finish;
    end
  end

  // Weighted instruction mix, funct3 random so OP under MULDIV_F7 hits MUL and DIV
  function automatic instr_t random_instr();
    int unsigned pick;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    reg_addr_t   rd;
    funct3_t     f3;
    funct7_t     f7;
    opcode_t     op;
    pick = $urandom_range(0, 99);
    rs1  = 5'($urandom_range(0, 3));
    rs2  = 5'($urandom_range(0, 3));
    rd   = 5'($urandom_range(0, 3));
    f3   = 3'($urandom_range(0, 7));
    f7   = 7'd0;
    if (pick < 20)
      op = OPC_OP;
    else if (pick < 30)
      op = OPC_OP_IMM;
    else if (pick < 45)
      op = OPC_LOAD;
    else if (pick < 55)
      op = OPC_STORE;
    else if (pick < 75)
    begin
      op = OPC_OP;
      f7 = MULDIV_F7;
    end
    else if (pick < 82)
      op = OPC_BRANCH;
    else if (pick < 87)
      op = pick[0] ? OPC_LUI : OPC_JAL;
    else if (pick < 93)
      op = OPC_SYSTEM;
    else if (pick < 98)
      op = OPC_MISC_MEM;
    else
      op = 7'b1111111;
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  // Commit the edge just passed, then drive the next cycle 1 ns later
  task automatic run_cycle();
    bit found;
    if (exp_disp)
    begin
      issued++;
      holding = 1'b0;
    end
    advance_model(exp_disp, late_wb_v, late_wb_rd);
    for (int r = 0; r < num_regs_lp; r++)
    begin
      if (wb_wait[r] > 0)
        wb_wait[r]--;
    end
    if (exp_disp && m_cls == PCLASS_LONG && m_w)
      wb_wait[m_rd] = $urandom_range(2, 10);
    #1;
    if (!holding)
    begin
      instr   = random_instr();
      instr_v = ($urandom_range(0, 4) != 0);
      holding = instr_v;
    end
    freeze     = ($urandom_range(0, 9) == 0);
    mem_ready  = ($urandom_range(0, 4) != 0);
    long_ready = ($urandom_range(0, 3) != 0);
    mem_idle   = ($urandom_range(0, 2) != 0);
    // At most one late writeback per cycle, oldest register number first
    found     = 1'b0;
    late_wb_v = 1'b0;
    for (int r = 1; r < num_regs_lp; r++)
    begin
      if (!found && sh_pend[r] && wb_wait[r] == 0)
      begin
        found      = 1'b1;
        late_wb_v  = 1'b1;
        late_wb_rd = 5'(r);
      end
    end
    decode_model(instr);
    exp_disp = expect_dispatch(instr_v, freeze, mem_ready, long_ready, mem_idle);
  endtask

  initial
  begin
    void'($urandom(seed_lp));
    clk        = 1'b0;
    rst_n      = 1'b0;
    instr_v    = 1'b0;
    instr      = '0;
    freeze     = 1'b0;
    mem_ready  = 1'b1;
    long_ready = 1'b1;
    mem_idle   = 1'b1;
    late_wb_v  = 1'b0;
    late_wb_rd = '0;
    exp_disp   = 1'b0;
    holding    = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    while (issued < num_instr_lp)
    begin
      @(posedge clk);
      run_cycle();
    end
    // A few more edges so the last driven cycle gets checked
    repeat (3)
    begin
      @(posedge clk);
      run_cycle();
    end
    $display("checks done: %0d dispatch mismatches, %0d rule violations",
             mismatch_cnt, rule_cnt);
    if (mismatch_cnt + rule_cnt == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

//--- project.f
+incdir+tb
hw/isa_pkg.sv
hw/issue_pkg.sv
hw/instr_decoder.sv
hw/reg_scoreboard.sv
hw/hazard_detector.sv
hw/issue_ctrl.sv
tb/issue_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the issue-stage testbench with Verilator.
# Pass is decided by the pass message in the simulation output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module issue_ctrl_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vissue_ctrl_tb 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Simulation completed successfully"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
